//--- verilog/uart_cfg.svh
// Build-time constants only; the divisor can still be changed at run time via the div register
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Clocks per serial bit, also the reset value of div
`define UART_CLKS_PER_BIT 16

// Entries in each of the receive and transmit FIFOs
`define UART_FIFO_DEPTH 8

// Width of a FIFO occupancy count, which must hold 0 to depth
`define UART_FIFO_CNT_W ($clog2(`UART_FIFO_DEPTH + 1))

// Receive watermark used by the echo sequencer
// Pending is raised when more entries than this are held
`define UART_ECHO_WATERMARK 0

`endif

//--- verilog/uart_pkg.sv
// Register layouts follow a 32-bit word map with no parity and one stop bit
package uart_pkg;

  typedef logic [7:0] uart_byte_t;

  // Word addresses of the register map
  typedef enum logic [2:0] {
    addr_txdata = 3'd0,
    addr_rxdata = 3'd1,
    addr_txctrl = 3'd2,
    addr_rxctrl = 3'd3,
    addr_ie     = 3'd4,
    addr_div    = 3'd5
  } uart_addr_e;

  // Receive watermark enable bit in the ie register
  localparam int ie_rxwm_bit = 1;

  // One received frame as held in the receive FIFO
  typedef struct packed {
    logic       frame_err;
    uart_byte_t data;
  } rx_entry_t;

  // Read word of rxdata
  typedef struct packed {
    logic        empty;
    logic        frame_err;
    logic [21:0] reserved;
    uart_byte_t  data;
  } rxdata_t;

  // Common layout of the transmit and receive control words
  typedef struct packed {
    logic [12:0] reserved_hi;
    logic [2:0]  watermark;
    logic [14:0] reserved_lo;
    logic        enable;
  } ctrl_word_t;

  typedef ctrl_word_t txctrl_t;
  typedef ctrl_word_t rxctrl_t;

endpackage

//--- verilog/uart_bus_if.sv
// Request is held with stable addr and wr_data until busy is low after the first cycle
interface uart_bus_if;

  logic                 rd_en;
  logic                 wr_en;
  uart_pkg::uart_addr_e addr;
  logic [31:0]          wr_data;
  logic [31:0]          rd_data;
  logic                 busy;

  // Side that issues register accesses
  modport controller (
    output rd_en, wr_en, addr, wr_data,
    input  rd_data, busy
  );

  // Register block side
  modport target (
    input  rd_en, wr_en, addr, wr_data,
    output rd_data, busy
  );

endinterface

//--- verilog/uart_fifo.sv
// Payload must be a packed type; a push while full is dropped and a pop while empty is ignored
`include "uart_cfg.svh"

module uart_fifo import uart_pkg::*; #(
  parameter type payload_t = uart_byte_t
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          push,
  input  payload_t                      push_data,
  input  logic                          pop,
  output payload_t                      pop_data,
  output logic                          empty,
  output logic                          full,
  output logic [`UART_FIFO_CNT_W-1:0]   count
);

  localparam int depth = `UART_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    next_ptr = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == `UART_FIFO_CNT_W'(depth));
  assign do_push  = push & ~full;
  assign do_pop   = pop & ~empty;
  // Head entry is visible without a pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

//--- verilog/uart_rx.sv
// Eight data bits, no parity, one stop bit; each bit is sampled once at mid-period
module uart_rx import uart_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        enable,
  input  logic [15:0] divisor,
  input  logic        rxd,
  output logic        rx_valid,
  output rx_entry_t   rx_entry
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } state_e;

  state_e      state;
  logic [1:0]  rxd_sync;
  logic        rxd_prev;
  logic [15:0] bit_cnt;
  logic [2:0]  bit_idx;
  uart_byte_t  shift;
  logic [15:0] half_period;
  logic        start_mid;
  logic        bit_end;
  logic        fall;

  assign half_period = divisor >> 1;
  assign start_mid   = (bit_cnt == half_period - 16'd1);
  assign bit_end     = (bit_cnt == divisor - 16'd1);
  // Falling edge of the synchronized line
  assign fall        = rxd_prev & ~rxd_sync[1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_sync <= 2'b11;
      rxd_prev <= 1'b1;
      state    <= st_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_prev <= rxd_sync[1];
      rx_valid <= 1'b0;
      if (!enable) begin
        state   <= st_idle;
        bit_cnt <= '0;
      end else begin
        case (state)
          st_idle: begin
            bit_cnt <= '0;
            if (fall) state <= st_start;
          end
          st_start: begin
            if (start_mid) begin
              bit_cnt <= '0;
              bit_idx <= '0;
              // Line back high at mid start means a glitch
              state   <= rxd_sync[1] ? st_idle : st_data;
            end else begin
              bit_cnt <= bit_cnt + 16'd1;
            end
          end
          st_data: begin
            if (bit_end) begin
              bit_cnt <= '0;
              bit_idx <= bit_idx + 3'd1;
              if (bit_idx == 3'd7) state <= st_stop;
            end else begin
              bit_cnt <= bit_cnt + 16'd1;
            end
          end
          st_stop: begin
            if (bit_end) begin
              bit_cnt  <= '0;
              rx_valid <= 1'b1;
              state    <= st_idle;
            end else begin
              bit_cnt <= bit_cnt + 16'd1;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clock) begin
    if (state == st_data && bit_end) shift <= {rxd_sync[1], shift[7:1]};
    if (state == st_stop && bit_end) begin
      rx_entry.data      <= shift;
      rx_entry.frame_err <= ~rxd_sync[1];
    end
  end

endmodule

//--- verilog/uart_tx.sv
// One start bit, eight data bits LSB first and one stop bit; a frame in flight finishes if disabled
module uart_tx import uart_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        enable,
  input  logic [15:0] divisor,
  input  logic        tx_valid,
  input  uart_byte_t  tx_byte,
  output logic        tx_ready,
  output logic        txd
);

  logic        active;
  logic [15:0] bit_cnt;
  logic [3:0]  bits_left;
  logic [8:0]  shift;
  logic        bit_end;
  logic        accept;

  assign bit_end  = (bit_cnt == divisor - 16'd1);
  assign tx_ready = enable & ~active;
  assign accept   = tx_valid & tx_ready;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      active    <= 1'b0;
      bit_cnt   <= '0;
      bits_left <= '0;
      txd       <= 1'b1;
    end else if (!active) begin
      if (accept) begin
        // Start bit goes out right away
        active    <= 1'b1;
        txd       <= 1'b0;
        bit_cnt   <= '0;
        bits_left <= 4'd9;
      end
    end else if (!bit_end) begin
      bit_cnt <= bit_cnt + 16'd1;
    end else begin
      bit_cnt <= '0;
      if (bits_left == 4'd0) begin
        // End of stop bit, txd is already high
        active <= 1'b0;
      end else begin
        txd       <= shift[0];
        bits_left <= bits_left - 4'd1;
      end
    end
  end

  // Data bits followed by the stop bit
  always_ff @(posedge clock) begin
    if (accept) begin
      shift <= {1'b1, tx_byte};
    end else if (active && bit_end && bits_left != 4'd0) begin
      shift <= shift >> 1;
    end
  end

endmodule

//--- verilog/uart_regs.sv
// Every access takes two cycles; the FIFO side effect of a request happens once, in its first cycle
`include "uart_cfg.svh"

module uart_regs import uart_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  uart_bus_if.target        bus,
  input  logic              rx_valid,
  input  rx_entry_t         rx_entry,
  output logic              tx_valid,
  output uart_byte_t        tx_byte,
  input  logic              tx_ready,
  output logic              tx_enable,
  output logic              rx_enable,
  output logic [15:0]       divisor,
  output logic              rx_pending
);

  localparam int cnt_w = `UART_FIFO_CNT_W;

  logic             in_access;
  logic             first;
  logic             rx_pop;
  logic             rx_empty;
  logic             tx_push;
  logic             tx_empty;
  logic             tx_full;
  logic [cnt_w-1:0] rx_count;
  logic [2:0]       rx_wm;
  logic             ie_rxwm;
  rx_entry_t        rx_head;
  txctrl_t          txctrl_wr;
  rxctrl_t          rxctrl_wr;
  txctrl_t          txctrl_rd;
  rxctrl_t          rxctrl_rd;
  rxdata_t          rx_word;
  logic [31:0]      rd_word;

  // Busy only in the first cycle of a request
  assign first    = (bus.rd_en | bus.wr_en) & ~in_access;
  assign bus.busy = first;

  assign tx_push  = first & bus.wr_en & (bus.addr == addr_txdata);
  assign rx_pop   = first & bus.rd_en & (bus.addr == addr_rxdata);

  assign tx_valid = ~tx_empty & tx_ready;

  assign rx_pending = ie_rxwm & (rx_count > cnt_w'(rx_wm));

  assign txctrl_wr = bus.wr_data;
  assign rxctrl_wr = bus.wr_data;

  uart_fifo #(.payload_t(rx_entry_t)) i_rx_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (rx_valid),
    .push_data (rx_entry),
    .pop       (rx_pop),
    .pop_data  (rx_head),
    .empty     (rx_empty),
    .full      (),
    .count     (rx_count)
  );

  uart_fifo #(.payload_t(uart_byte_t)) i_tx_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (tx_push),
    .push_data (bus.wr_data[7:0]),
    .pop       (tx_valid),
    .pop_data  (tx_byte),
    .empty     (tx_empty),
    .full      (tx_full),
    .count     ()
  );

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      in_access <= 1'b0;
      tx_enable <= 1'b0;
      rx_enable <= 1'b0;
      rx_wm     <= '0;
      ie_rxwm   <= 1'b0;
      divisor   <= 16'(`UART_CLKS_PER_BIT);
    end else begin
      in_access <= first;
      if (first && bus.wr_en) begin
        case (bus.addr)
          addr_txctrl: tx_enable <= txctrl_wr.enable;
          addr_rxctrl: begin
            rx_enable <= rxctrl_wr.enable;
            rx_wm     <= rxctrl_wr.watermark;
          end
          addr_ie:  ie_rxwm <= bus.wr_data[ie_rxwm_bit];
          addr_div: divisor <= bus.wr_data[15:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rx_word           = '0;
    rx_word.empty     = rx_empty;
    rx_word.frame_err = rx_head.frame_err & ~rx_empty;
    rx_word.data      = rx_empty ? '0 : rx_head.data;
    txctrl_rd         = '0;
    txctrl_rd.enable  = tx_enable;
    rxctrl_rd           = '0;
    rxctrl_rd.enable    = rx_enable;
    rxctrl_rd.watermark = rx_wm;
    rd_word = '0;
    case (bus.addr)
      addr_txdata: rd_word[31] = tx_full;
      addr_rxdata: rd_word = rx_word;
      addr_txctrl: rd_word = txctrl_rd;
      addr_rxctrl: rd_word = rxctrl_rd;
      addr_ie:     rd_word[ie_rxwm_bit] = ie_rxwm;
      addr_div:    rd_word[15:0] = divisor;
      default:     rd_word = '0;
    endcase
  end

  // Captured in the first cycle, valid when busy falls
  always_ff @(posedge clock) begin
    if (first && bus.rd_en) bus.rd_data <= rd_word;
  end

endmodule

//--- verilog/uart_echo_ctrl.sv
// Programs the UART once after reset, then echoes every received byte; framing errors are dropped
`include "uart_cfg.svh"

module uart_echo_ctrl import uart_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  uart_bus_if.controller bus,
  input  logic           rx_pending
);

  typedef enum logic [2:0] {
    st_idle,
    st_div,
    st_rxctrl,
    st_txctrl,
    st_ie,
    st_wait,
    st_read,
    st_write
  } state_e;

  localparam rxctrl_t rxctrl_cfg = '{
    watermark: 3'(`UART_ECHO_WATERMARK),
    enable:    1'b1,
    default:   '0
  };
  localparam txctrl_t txctrl_cfg = '{enable: 1'b1, default: '0};

  state_e     state;
  state_e     state_next;
  uart_byte_t echo_byte;
  rxdata_t    rd_word;

  assign rd_word = bus.rd_data;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) state <= st_idle;
    else state <= state_next;
  end

  // Keep the byte for the write that follows the read
  always_ff @(posedge clock) begin
    if (state == st_read && !bus.busy) echo_byte <= rd_word.data;
  end

  // Each access state holds its request until busy falls
  always_comb begin
    state_next  = state;
    bus.rd_en   = 1'b0;
    bus.wr_en   = 1'b0;
    bus.addr    = addr_txdata;
    bus.wr_data = '0;
    case (state)
      st_idle: state_next = st_div;
      st_div: begin
        bus.wr_en   = 1'b1;
        bus.addr    = addr_div;
        bus.wr_data = 32'(`UART_CLKS_PER_BIT);
        if (!bus.busy) state_next = st_rxctrl;
      end
      st_rxctrl: begin
        bus.wr_en   = 1'b1;
        bus.addr    = addr_rxctrl;
        bus.wr_data = rxctrl_cfg;
        if (!bus.busy) state_next = st_txctrl;
      end
      st_txctrl: begin
        bus.wr_en   = 1'b1;
        bus.addr    = addr_txctrl;
        bus.wr_data = txctrl_cfg;
        if (!bus.busy) state_next = st_ie;
      end
      st_ie: begin
        bus.wr_en   = 1'b1;
        bus.addr    = addr_ie;
        bus.wr_data = 32'h1 << ie_rxwm_bit;
        if (!bus.busy) state_next = st_wait;
      end
      st_wait: begin
        if (rx_pending) state_next = st_read;
      end
      st_read: begin
        bus.rd_en = 1'b1;
        bus.addr  = addr_rxdata;
        if (!bus.busy) begin
          // Bad frames are popped but not sent back
          if (rd_word.empty || rd_word.frame_err) state_next = st_wait;
          else state_next = st_write;
        end
      end
      st_write: begin
        bus.wr_en   = 1'b1;
        bus.addr    = addr_txdata;
        bus.wr_data = {24'h0, echo_byte};
        if (!bus.busy) state_next = st_wait;
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

//--- verilog/uart_echo_top.sv
// Serial lines are asynchronous to clock; the bit rate is clock divided by UART_CLKS_PER_BIT
module uart_echo_top import uart_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic rxd,
  output logic txd,
  output logic rx_pending
);

  logic        rx_valid;
  rx_entry_t   rx_entry;
  logic        tx_valid;
  uart_byte_t  tx_byte;
  logic        tx_ready;
  logic        tx_enable;
  logic        rx_enable;
  logic [15:0] divisor;

  uart_bus_if bus ();

  uart_echo_ctrl i_uart_echo_ctrl (
    .clock      (clock),
    .reset      (reset),
    .bus        (bus),
    .rx_pending (rx_pending)
  );

  uart_regs i_uart_regs (
    .clock      (clock),
    .reset      (reset),
    .bus        (bus),
    .rx_valid   (rx_valid),
    .rx_entry   (rx_entry),
    .tx_valid   (tx_valid),
    .tx_byte    (tx_byte),
    .tx_ready   (tx_ready),
    .tx_enable  (tx_enable),
    .rx_enable  (rx_enable),
    .divisor    (divisor),
    .rx_pending (rx_pending)
  );

  uart_rx i_uart_rx (
    .clock    (clock),
    .reset    (reset),
    .enable   (rx_enable),
    .divisor  (divisor),
    .rxd      (rxd),
    .rx_valid (rx_valid),
    .rx_entry (rx_entry)
  );

  uart_tx i_uart_tx (
    .clock    (clock),
    .reset    (reset),
    .enable   (tx_enable),
    .divisor  (divisor),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .txd      (txd)
  );

endmodule

//--- tb/uart_echo_props.sv
// Bound into uart_regs; covers the register bus handshake and the transmit strobe only
module uart_echo_props import uart_pkg::*; (
  input logic       clock,
  input logic       reset,
  input logic       rd_en,
  input logic       wr_en,
  input uart_addr_e addr,
  input logic       busy,
  input logic       tx_valid,
  input logic       tx_ready,
  input logic       tx_enable
);

  // Busy lasts one cycle and the request is held unchanged into the cycle where busy falls
  request_held: assert property (
    @(posedge clock) disable iff (reset)
      busy |=> !busy && (rd_en || wr_en) &&
               $stable(rd_en) && $stable(wr_en) && $stable(addr)
  ) else $error("request or addr changed, or busy stayed high, in the second cycle");

  // Strobe only with ready, and the transmitter leaves idle right after
  tx_strobe_ready: assert property (
    @(posedge clock) disable iff (reset) tx_valid |-> tx_ready ##1 !tx_ready
  ) else $error("tx_valid without tx_ready or not taken by the transmitter");

  // Disabled transmitter keeps txd idle
  tx_idle_disabled: assert property (
    @(posedge clock) disable iff (reset) !tx_enable |-> !tx_valid
  ) else $error("tx_valid while the transmitter is disabled");

endmodule

bind uart_regs uart_echo_props i_uart_echo_props (
  .clock     (clock),
  .reset     (reset),
  .rd_en     (bus.rd_en),
  .wr_en     (bus.wr_en),
  .addr      (bus.addr),
  .busy      (bus.busy),
  .tx_valid  (tx_valid),
  .tx_ready  (tx_ready),
  .tx_enable (tx_enable)
);

//--- tb/uart_echo_tb.sv
// Assumes the sequencer keeps the divisor at UART_CLKS_PER_BIT, which must be even
`include "uart_cfg.svh"

module uart_echo_tb import uart_pkg::*; ();

  localparam int cpb             = `UART_CLKS_PER_BIT;
  localparam int frame_cycles    = 10 * cpb;
  localparam int reset_cycles    = 16;
  localparam int burst_len       = 20;
  localparam int total_frames    = 1 + burst_len + 2 + 1;
  localparam int watchdog_cycles = total_frames * 10 * cpb * 3;

  logic       clock;
  logic       reset;
  logic       rxd;
  logic       txd;
  logic       rx_pending;
  uart_byte_t echo_model[$];
  bit         mon_busy;
  int         error_count;
  int         tests_run;
  int         tests_passed;

  always #20 clock = ~clock;

  uart_echo_top i_uart_echo_top (
    .clock      (clock),
    .reset      (reset),
    .rxd        (rxd),
    .txd        (txd),
    .rx_pending (rx_pending)
  );

  task automatic note_failure(string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_byte(uart_byte_t actual, uart_byte_t expected_val, string what);
    if (actual !== expected_val) begin
      error_count++;
      $display("Mismatch at %0t: %s expected 0x%02h got 0x%02h",
               $time, what, expected_val, actual);
    end
  endtask

  task automatic check_idle(logic actual, logic expected_val, string what);
    if (actual !== expected_val) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, what, expected_val, actual);
    end
  endtask

  task automatic report_test(string name, int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      tests_passed++;
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               error_count - errs_before);
    end
  endtask

  // One frame on rxd, LSB first, then an idle gap of whole bits
  task automatic send_frame(uart_byte_t data, bit bad_stop, int gap_bits);
    if (!bad_stop) echo_model.push_back(data);
    rxd = 1'b0;
    repeat (cpb) @(negedge clock);
    for (int b = 0; b < 8; b++) begin
      rxd = data[b];
      repeat (cpb) @(negedge clock);
    end
    rxd = ~bad_stop;
    repeat (cpb) @(negedge clock);
    rxd = 1'b1;
    repeat (gap_bits * cpb) @(negedge clock);
  endtask

  task automatic wait_echo_drain(int limit);
    int waited;
    waited = 0;
    while ((echo_model.size() != 0 || mon_busy) && waited < limit) begin
      @(negedge clock);
      waited++;
    end
    if (echo_model.size() != 0 || mon_busy)
      note_failure($sformatf("%0d bytes were never echoed on txd", echo_model.size()));
  endtask

  // Pending must rise for the frame and drop again while txd is still idle
  task automatic watch_pending(int limit);
    int waited;
    waited = 0;
    while (rx_pending !== 1'b1 && waited < limit) begin
      @(negedge clock);
      waited++;
    end
    if (rx_pending !== 1'b1) begin
      note_failure("rx_pending never rose after a received frame");
    end else begin
      waited = 0;
      while (rx_pending !== 1'b0 && waited < limit) begin
        @(negedge clock);
        waited++;
      end
      if (rx_pending !== 1'b0) note_failure("rx_pending never fell after the byte was read");
      check_idle(txd, 1'b1, "txd when rx_pending falls");
      if (mon_busy) note_failure("echo started on txd before rx_pending fell");
    end
  endtask

  task automatic record_echo(uart_byte_t data);
    if (echo_model.size() == 0) note_failure($sformatf("unexpected byte 0x%02h on txd", data));
    else check_byte(data, echo_model.pop_front(), "echoed byte");
  endtask

  // Decodes txd at mid-bit, sampled on the falling edge
  initial begin : txd_monitor
    uart_byte_t data;
    forever begin
      @(negedge clock);
      if (!reset && txd === 1'b0) begin
        mon_busy = 1'b1;
        repeat (cpb / 2) @(negedge clock);
        check_idle(txd, 1'b0, "txd in middle of start bit");
        for (int b = 0; b < 8; b++) begin
          repeat (cpb) @(negedge clock);
          data[b] = txd;
        end
        repeat (cpb) @(negedge clock);
        check_idle(txd, 1'b1, "txd stop bit");
        record_echo(data);
        mon_busy = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    int         errs;
    uart_byte_t good;
    uart_byte_t bad;
    clock        = 1'b0;
    reset        = 1'b1;
    rxd          = 1'b1;
    mon_busy     = 1'b0;
    error_count  = 0;
    tests_run    = 0;
    tests_passed = 0;
    void'($urandom(32'h8b2c_224b));

    errs = error_count;
    for (int i = 0; i < reset_cycles + 32; i++) begin
      @(negedge clock);
      check_idle(txd, 1'b1, "txd during reset and configuration");
      check_idle(rx_pending, 1'b0, "rx_pending during reset and configuration");
      if (i == reset_cycles - 1) reset = 1'b0;
    end
    report_test("reset and configuration idle", errs);

    errs = error_count;
    send_frame(uart_byte_t'($urandom_range(255, 0)), 1'b0, 2);
    wait_echo_drain(4 * frame_cycles);
    report_test("single byte echo", errs);

    errs = error_count;
    for (int i = 0; i < burst_len; i++)
      send_frame(uart_byte_t'($urandom_range(255, 0)), 1'b0, int'($urandom_range(3, 1)));
    wait_echo_drain(4 * frame_cycles);
    report_test("burst echo in order", errs);

    // Bad frame first, so a wrong echo shows up against the good byte
    errs = error_count;
    bad  = uart_byte_t'($urandom_range(255, 0));
    good = ~bad;
    send_frame(bad, 1'b1, int'($urandom_range(3, 1)));
    send_frame(good, 1'b0, 2);
    wait_echo_drain(4 * frame_cycles);
    repeat (frame_cycles) @(negedge clock);
    report_test("framing error dropped", errs);

    errs = error_count;
    fork
      send_frame(uart_byte_t'($urandom_range(255, 0)), 1'b0, 2);
      watch_pending(2 * frame_cycles);
    join
    wait_echo_drain(4 * frame_cycles);
    report_test("rx_pending before echo", errs);

    $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- uart_echo.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_bus_if.sv
verilog/uart_fifo.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_regs.sv
verilog/uart_echo_ctrl.sv
verilog/uart_echo_top.sv
tb/uart_echo_props.sv
tb/uart_echo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_echo_tb -f uart_echo.f -o uart_echo_sim

./obj_dir/uart_echo_sim | tee "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
